/* hdl/bus_pkg.sv */
package bus_pkg;

    // ==================================================
    // host bus widths
    // ==================================================

    localparam int BUS_ADDR_W = 16;
    localparam int BUS_DATA_W = 8;

    // byte address as seen on the host bus
    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;

    // one data byte, used for both write data and the read return
    typedef logic [BUS_DATA_W-1:0] bus_data_t;

    // ==================================================
    // request
    // ==================================================

    // one access per cycle, rd and wr are never high together
    typedef struct packed {
        bus_addr_t add;
        bus_data_t wr_data;
        logic      rd;
        logic      wr;
    } bus_req_t;

endpackage

/* hdl/gpio_pkg.sv */
package gpio_pkg;

    // ==================================================
    // register map of one I/O block
    // ==================================================

    // value returned when the version register is read
    localparam logic [7:0] GPIO_VERSION = 8'd0;

    // offset 0 reads the version, a write here is a soft reset
    localparam int unsigned GPIO_REG_VERSION = 0;

    // the input section starts right behind the version byte,
    // output and direction sections follow with the same size
    localparam int unsigned GPIO_REG_INPUT = GPIO_REG_VERSION + 1;

    // bits per register byte, used to size the sections
    localparam int unsigned GPIO_BYTE_W = 8;

endpackage

/* hdl/bus_to_ip.sv */
`timescale 1ns/1ps

module bus_to_ip import bus_pkg::*; #(
    parameter bus_addr_t base_addr = '0,
    parameter bus_addr_t high_addr = '0
) (
    input  bus_req_t  bus_req,
    output bus_addr_t ip_add,
    output logic      ip_sel,
    output logic      ip_rd,
    output logic      ip_wr,
    output bus_data_t ip_wr_data
);

    // size of the window minus one
    localparam bus_addr_t span = high_addr - base_addr;

    // addresses below base_addr wrap to large values, so a single
    // unsigned compare against the span covers both window edges
    assign ip_add = bus_req.add - base_addr;
    assign ip_sel = (ip_add <= span);

    // only accesses inside the window reach the block
    assign ip_rd = bus_req.rd & ip_sel;
    assign ip_wr = bus_req.wr & ip_sel;

    assign ip_wr_data = bus_req.wr_data;

endmodule

/* hdl/gpio.sv */
`timescale 1ns/1ps

module gpio import bus_pkg::*, gpio_pkg::*; #(
    parameter bus_addr_t             base_addr    = '0,
    parameter bus_addr_t             high_addr    = '0,
    parameter int                    io_width     = 8,
    parameter logic [io_width-1:0]   io_direction = '0,
    parameter logic [io_width-1:0]   io_tri       = '0
) (
    input  logic                BUS_CLK,
    input  logic                RST,
    input  bus_req_t            bus_req,
    input  logic [io_width-1:0] io_in,
    output bus_data_t           rd_data,
    output logic [io_width-1:0] io_out,
    output logic [io_width-1:0] io_oe
);

    // register bytes per section and the padded section width
    localparam int nbytes = (io_width + GPIO_BYTE_W - 1) / GPIO_BYTE_W;
    localparam int pad_w  = nbytes * GPIO_BYTE_W;

    // first offset of each section and the first unused offset behind them
    localparam bus_addr_t ver_off = bus_addr_t'(GPIO_REG_VERSION);
    localparam bus_addr_t in_lo   = bus_addr_t'(GPIO_REG_INPUT);
    localparam bus_addr_t out_lo  = in_lo + bus_addr_t'(nbytes);
    localparam bus_addr_t dir_lo  = out_lo + bus_addr_t'(nbytes);
    localparam bus_addr_t map_end = dir_lo + bus_addr_t'(nbytes);

    bus_addr_t ip_add;
    logic      ip_sel;
    logic      ip_rd;
    logic      ip_wr;
    bus_data_t ip_wr_data;

    bus_to_ip #(
        .base_addr (base_addr),
        .high_addr (high_addr)
    ) u_bus_to_ip (
        .bus_req    (bus_req),
        .ip_add     (ip_add),
        .ip_sel     (ip_sel),
        .ip_rd      (ip_rd),
        .ip_wr      (ip_wr),
        .ip_wr_data (ip_wr_data)
    );

    // ==================================================
    // address decode
    // ==================================================

    logic ver_hit;
    logic in_hit;
    logic out_hit;
    logic dir_hit;
    logic soft_rst;

    // the relative offset only means something inside the window
    assign ver_hit = ip_sel && (ip_add == ver_off);
    assign in_hit  = ip_sel && (ip_add >= in_lo) && (ip_add < out_lo);
    assign out_hit = ip_sel && (ip_add >= out_lo) && (ip_add < dir_lo);
    assign dir_hit = ip_sel && (ip_add >= dir_lo) && (ip_add < map_end);

    assign soft_rst = ip_wr && ver_hit;

    // byte index inside a section with the most significant byte at the lowest offset
    bus_addr_t in_idx;
    bus_addr_t out_idx;
    bus_addr_t dir_idx;

    assign in_idx  = (out_lo - bus_addr_t'(1)) - ip_add;
    assign out_idx = (dir_lo - bus_addr_t'(1)) - ip_add;
    assign dir_idx = (map_end - bus_addr_t'(1)) - ip_add;

    function automatic bus_data_t get_byte(input logic [pad_w-1:0] v, input bus_addr_t idx);
        bus_data_t b;
        b = '0;
        for (int i = 0; i < nbytes; i++) begin
            if (idx == bus_addr_t'(i)) begin
                b = v[i*GPIO_BYTE_W +: GPIO_BYTE_W];
            end
        end
        return b;
    endfunction

    function automatic logic [pad_w-1:0] put_byte(input logic [pad_w-1:0] v,
                                                   input bus_addr_t idx,
                                                   input bus_data_t b);
        logic [pad_w-1:0] r;
        r = v;
        for (int i = 0; i < nbytes; i++) begin
            if (idx == bus_addr_t'(i)) begin
                r[i*GPIO_BYTE_W +: GPIO_BYTE_W] = b;
            end
        end
        return r;
    endfunction

    // ==================================================
    // register file
    // ==================================================

    logic [io_width-1:0] out_q;
    logic [io_width-1:0] dir_q;
    logic [pad_w-1:0]    in_pad;
    logic [pad_w-1:0]    out_pad;
    logic [pad_w-1:0]    dir_pad;
    logic [pad_w-1:0]    out_wr;
    logic [pad_w-1:0]    dir_wr;

    // unused high bits of the top byte read back as zero
    assign in_pad  = pad_w'(io_in);
    assign out_pad = pad_w'(out_q);
    assign dir_pad = pad_w'(dir_q);

    assign out_wr = put_byte(out_pad, out_idx, ip_wr_data);
    assign dir_wr = put_byte(dir_pad, dir_idx, ip_wr_data);

    // writes to the input section fall through and are ignored
    always_ff @(posedge BUS_CLK) begin
        if (RST || soft_rst) begin
            out_q <= '0;
            dir_q <= '0;
        end else if (ip_wr && out_hit) begin
            out_q <= out_wr[io_width-1:0];
        end else if (ip_wr && dir_hit) begin
            dir_q <= dir_wr[io_width-1:0];
        end
    end

    // io_in is sampled into the read return on the read edge itself
    bus_data_t rd_mux;

    always_comb begin
        if (ver_hit) begin
            rd_mux = GPIO_VERSION;
        end else if (in_hit) begin
            rd_mux = get_byte(in_pad, in_idx);
        end else if (out_hit) begin
            rd_mux = get_byte(out_pad, out_idx);
        end else if (dir_hit) begin
            rd_mux = get_byte(dir_pad, dir_idx);
        end else begin
            rd_mux = '0;
        end
    end

    // zero when idle so the top level can OR the blocks together
    always_ff @(posedge BUS_CLK) begin
        if (RST || !ip_rd) begin
            rd_data <= '0;
        end else begin
            rd_data <= rd_mux;
        end
    end

    // ==================================================
    // pin drive
    // ==================================================

    for (genvar i = 0; i < io_width; i++) begin : g_pin
        if (io_tri[i]) begin : g_tri
            assign io_out[i] = out_q[i];
            assign io_oe[i]  = dir_q[i];
        end else if (io_direction[i]) begin : g_out
            assign io_out[i] = out_q[i];
            assign io_oe[i]  = 1'b1;
        end else begin : g_in
            assign io_out[i] = 1'b0;
            assign io_oe[i]  = 1'b0;
        end
    end

endmodule

/* hdl/gpio_subsys.sv */
`timescale 1ns/1ps

module gpio_subsys import bus_pkg::*; (
    input  logic       BUS_CLK,
    input  logic       RST,
    input  bus_req_t   bus_req,
    input  logic [11:0] io_a_in,
    input  logic [7:0]  io_b_in,
    output bus_data_t  rd_data,
    output logic [11:0] io_a_out,
    output logic [11:0] io_a_oe,
    output logic [7:0]  io_b_out,
    output logic [7:0]  io_b_oe
);

    // ==================================================
    // block A, twelve three-state pins
    // ==================================================

    localparam bus_addr_t a_base_addr = 16'h0000;
    localparam bus_addr_t a_high_addr = 16'h000F;

    bus_data_t rd_data_a;

    gpio #(
        .base_addr    (a_base_addr),
        .high_addr    (a_high_addr),
        .io_width     (12),
        .io_direction (12'h000),
        .io_tri       (12'hFFF)
    ) u_gpio_a (
        .BUS_CLK (BUS_CLK),
        .RST     (RST),
        .bus_req (bus_req),
        .io_in   (io_a_in),
        .rd_data (rd_data_a),
        .io_out  (io_a_out),
        .io_oe   (io_a_oe)
    );

    // ==================================================
    // block B, upper nibble driven, lower nibble input only
    // ==================================================

    localparam bus_addr_t b_base_addr = 16'h0010;
    localparam bus_addr_t b_high_addr = 16'h001F;

    bus_data_t rd_data_b;

    gpio #(
        .base_addr    (b_base_addr),
        .high_addr    (b_high_addr),
        .io_width     (8),
        .io_direction (8'hF0),
        .io_tri       (8'h00)
    ) u_gpio_b (
        .BUS_CLK (BUS_CLK),
        .RST     (RST),
        .bus_req (bus_req),
        .io_in   (io_b_in),
        .rd_data (rd_data_b),
        .io_out  (io_b_out),
        .io_oe   (io_b_oe)
    );

    // each block returns zero unless it was read, so an OR is enough
    // and a miss on both windows reads as zero
    assign rd_data = rd_data_a | rd_data_b;

endmodule

/* test/tb_gpio_tasks.svh */
// steps at least one edge and goes on until cycle_no reaches target
task automatic wait_cycle(input int unsigned target, input bit falling, input string what);
    int unsigned guard;
    guard = 0;
    do begin
        if (falling) begin
            @(negedge BUS_CLK);
        end else begin
            @(posedge BUS_CLK);
        end
        guard++;
        if (cycle_no < target && guard >= WAIT_LIMIT) begin
            stop_with_failure($sformatf("Timeout: no %s within %0d clock edges", what, guard));
        end
    end while (cycle_no < target);
endtask

// the request of one access is driven on a rising edge and taken on the next one
task automatic bus_access(input bus_req_t req, output bus_data_t data);
    int unsigned issue;
    wait_cycle(cycle_no + 1, 1'b0, "edge to drive the request");
    issue = cycle_no;
    bus_req <= req;
    wait_cycle(issue + 1, 1'b0, "edge that takes the request");
    bus_req <= '0;
    // rd_data was registered on that edge and is stable by the falling edge
    wait_cycle(issue + 1, 1'b1, "read data edge");
    data = rd_data;
endtask

task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
    bus_req_t  req;
    bus_data_t ignored;
    req         = '0;
    req.add     = addr;
    req.wr_data = data;
    req.wr      = 1'b1;
    bus_access(req, ignored);
endtask

task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
    bus_req_t req;
    req     = '0;
    req.add = addr;
    req.rd  = 1'b1;
    bus_access(req, data);
endtask

/* test/tb_gpio_subsys.sv */
`timescale 1ns/1ps

module tb_gpio_subsys import bus_pkg::*, gpio_pkg::*; ();

    // edges a single wait may take before the run counts as hung
    localparam int unsigned WAIT_LIMIT = 4;
    localparam int          ROUNDS     = 4;

    logic        BUS_CLK = 1'b0;
    logic        RST;
    bus_req_t    bus_req;
    logic [11:0] io_a_in;
    logic [7:0]  io_b_in;
    bus_data_t   rd_data;
    logic [11:0] io_a_out;
    logic [11:0] io_a_oe;
    logic [7:0]  io_b_out;
    logic [7:0]  io_b_oe;

    gpio_subsys u_gpio_subsys (
        .BUS_CLK  (BUS_CLK),
        .RST      (RST),
        .bus_req  (bus_req),
        .io_a_in  (io_a_in),
        .io_b_in  (io_b_in),
        .rd_data  (rd_data),
        .io_a_out (io_a_out),
        .io_a_oe  (io_a_oe),
        .io_b_out (io_b_out),
        .io_b_oe  (io_b_oe)
    );

    always #10 BUS_CLK = ~BUS_CLK;

    // counts falling edges, so a rising edge and the falling edge after it
    // see the same value
    int unsigned cycle_no;

    always @(negedge BUS_CLK) begin
        cycle_no <= cycle_no + 1;
    end

    // expected register contents of both blocks
    logic [11:0] out_a;
    logic [11:0] dir_a;
    bus_data_t   out_b;
    bus_data_t   dir_b;

    logic [31:0] lfsr_state = 32'h8eb2_892e;

    // ==================================================
    // helpers
    // ==================================================

    // taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic expect_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
        assert (got === exp) else begin
            stop_with_failure($sformatf("Mismatch at %0t: %s is 0x%0h, expected 0x%0h",
                                        $time, name, got, exp));
        end
    endtask

    `include "tb_gpio_tasks.svh"

    task automatic read_expect(input bus_addr_t addr, input bus_data_t exp);
        bus_data_t got;
        bus_read(addr, got);
        expect_eq($sformatf("rd_data at 0x%04h", addr), {8'h00, got}, {8'h00, exp});
    endtask

    task automatic drive_inputs(input logic [11:0] a_val, input logic [7:0] b_val);
        wait_cycle(cycle_no + 1, 1'b0, "edge to drive the pins");
        io_a_in <= a_val;
        io_b_in <= b_val;
    endtask

    // block A has two bytes per section and only the low nibble of the upper one is real
    task automatic write_a_random();
        logic [15:0] r_out;
        logic [15:0] r_dir;
        r_out = random_bits(16);
        r_dir = random_bits(16);
        bus_write(16'h0003, r_out[15:8]);
        bus_write(16'h0004, r_out[7:0]);
        bus_write(16'h0005, r_dir[15:8]);
        bus_write(16'h0006, r_dir[7:0]);
        out_a = r_out[11:0];
        dir_a = r_dir[11:0];
    endtask

    task automatic write_b_random();
        logic [15:0] r;
        r = random_bits(16);
        bus_write(16'h0012, r[15:8]);
        bus_write(16'h0013, r[7:0]);
        out_b = r[15:8];
        dir_b = r[7:0];
    endtask

    task automatic check_a_regs();
        read_expect(16'h0003, {4'h0, out_a[11:8]});
        read_expect(16'h0004, out_a[7:0]);
        read_expect(16'h0005, {4'h0, dir_a[11:8]});
        read_expect(16'h0006, dir_a[7:0]);
    endtask

    task automatic check_b_regs();
        read_expect(16'h0012, out_b);
        read_expect(16'h0013, dir_b);
    endtask

    task automatic check_inputs(input logic [11:0] in_a, input bus_data_t in_b);
        read_expect(16'h0001, {4'h0, in_a[11:8]});
        read_expect(16'h0002, in_a[7:0]);
        read_expect(16'h0011, in_b);
    endtask

    // B drives its upper nibble always and never drives the lower one
    task automatic check_pins();
        expect_eq("io_a_out", {4'h0, io_a_out}, {4'h0, out_a});
        expect_eq("io_a_oe", {4'h0, io_a_oe}, {4'h0, dir_a});
        expect_eq("io_b_oe", {8'h00, io_b_oe}, 16'h00F0);
        expect_eq("io_b_out", {8'h00, io_b_out}, {8'h00, out_b[7:4], 4'h0});
    endtask

    // ==================================================
    // stimulus
    // ==================================================

    initial begin
        logic [15:0] r;
        logic [11:0] in_a;
        bus_data_t   in_b;

        RST     <= 1'b1;
        bus_req <= '0;
        // pins start at random levels so the version read differs from the input bytes
        r = random_bits(12);
        io_a_in <= r[11:0];
        r = random_bits(8);
        io_b_in <= r[7:0];
        out_a = '0;
        dir_a = '0;
        out_b = '0;
        dir_b = '0;

        wait_cycle(1, 1'b0, "reset release edge");
        RST <= 1'b0;

        read_expect(16'h0000, GPIO_VERSION);
        read_expect(16'h0010, GPIO_VERSION);
        expect_eq("io_a_oe", {4'h0, io_a_oe}, 16'h0000);
        check_pins();

        for (int n = 0; n < ROUNDS; n++) begin
            write_a_random();
            write_b_random();
            check_a_regs();
            check_b_regs();
            read_expect(16'h0000, GPIO_VERSION);
            read_expect(16'h0010, GPIO_VERSION);
            check_pins();
        end

        // inputs read back and writes to the input section must not stick anywhere
        for (int n = 0; n < ROUNDS; n++) begin
            r    = random_bits(12);
            in_a = r[11:0];
            r    = random_bits(8);
            in_b = r[7:0];
            drive_inputs(in_a, in_b);
            check_inputs(in_a, in_b);
            r = random_bits(8);
            bus_write(16'h0001, r[7:0]);
            bus_write(16'h0002, r[7:0]);
            bus_write(16'h0011, r[7:0]);
            check_inputs(in_a, in_b);
            check_a_regs();
            check_b_regs();
        end

        // soft reset of block A only
        write_a_random();
        r = random_bits(8);
        bus_write(16'h0000, r[7:0]);
        out_a = '0;
        dir_a = '0;
        check_a_regs();
        check_b_regs();
        check_pins();

        // unmapped addresses read zero and ignore writes
        write_a_random();
        read_expect(16'h0030, 8'h00);
        read_expect(16'h0007, 8'h00);
        read_expect(16'h000F, 8'h00);
        read_expect(16'h0014, 8'h00);
        read_expect(16'h001F, 8'h00);
        r = random_bits(8);
        bus_write(16'h0030, r[7:0]);
        check_a_regs();
        check_b_regs();
        check_pins();

        $display("** PASS **");
        $finish;
    end

endmodule

/* all.f */
+incdir+test
hdl/bus_pkg.sv
hdl/gpio_pkg.sv
hdl/bus_to_ip.sv
hdl/gpio.sv
hdl/gpio_subsys.sv
test/tb_gpio_subsys.sv

/* Makefile */
SIM      := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP      := tb_gpio_subsys
FILELIST := all.f
OBJDIR   := obj_dir
PASS_MSG := ** PASS **

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
